// File: Bender.yml
package:
  name: ex_stage

sources:
  # Packages first, then RTL bottom-up
  - logic/ex_cfg_pkg.sv
  - logic/ex_op_pkg.sv
  - logic/ex_alu.sv
  - logic/ex_mult.sv
  - logic/ex_wb_reg.sv
  - logic/ex_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_ex_stage.sv

// File: ex_stage.f
+incdir+include
logic/ex_cfg_pkg.sv
logic/ex_op_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_wb_reg.sv
logic/ex_stage.sv
testbench/tb_ex_stage.sv

// File: logic/ex_alu.sv
//////////////////////////////////////////////////////////////////////
// Single-cycle ALU, purely combinational
// Shift amount is the low log2(XLEN) bits of operand B
// cmp_result_o is low for every non-comparison opcode
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module ex_alu #(
  parameter int unsigned XLEN = 32
) (
  input  ex_op_pkg::alu_op_e operator_i,
  input  logic [XLEN-1:0]    operand_a_i,
  input  logic [XLEN-1:0]    operand_b_i,
  output logic [XLEN-1:0]    result_o,
  output logic               cmp_result_o
);

  localparam int unsigned SHAMT_W = $clog2(XLEN);

  // Shift amount
  logic [SHAMT_W-1:0] shamt;

  // Comparator outputs
  logic is_equal;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = operand_b_i[SHAMT_W-1:0];

  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  // Branch opcodes share the comparator with SLT/SLTU
  always_comb begin
    case (operator_i)
      ex_op_pkg::ALU_SLT,
      ex_op_pkg::ALU_LT:   cmp_result_o = lt_signed;
      ex_op_pkg::ALU_SLTU,
      ex_op_pkg::ALU_LTU:  cmp_result_o = lt_unsigned;
      ex_op_pkg::ALU_EQ:   cmp_result_o = is_equal;
      ex_op_pkg::ALU_NE:   cmp_result_o = !is_equal;
      ex_op_pkg::ALU_GE:   cmp_result_o = !lt_signed;
      ex_op_pkg::ALU_GEU:  cmp_result_o = !lt_unsigned;
      default:             cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      // Arithmetic
      ex_op_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ex_op_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      // Bitwise logic
      ex_op_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_op_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_op_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      // Shifts
      ex_op_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_op_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic right shift keeps the sign bit
      ex_op_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Every comparison writes 0 or 1
      default:             result_o = XLEN'(cmp_result_o);
    endcase
  end

endmodule : ex_alu

`default_nettype wire

// File: logic/ex_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Datapath sizing for the execute stage
// Values serve only as parameter defaults at the top level
// XLEN may be 16, 32 or 64; other widths are not supported
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ex_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data width
  //////////////////////////////////////////////////////////////////////

  // Width of operands, results and the register file data port
  parameter int unsigned XLEN = 32;

  //////////////////////////////////////////////////////////////////////
  // Register file addressing
  //////////////////////////////////////////////////////////////////////

  // 32 architectural registers
  parameter int unsigned REGADDR_W = 5;

endpackage : ex_cfg_pkg

`default_nettype wire

// File: logic/ex_mult.sv
//////////////////////////////////////////////////////////////////////
// Iterative shift-add multiplier, unsigned operands only
// XLEN cycles in MUL_CALC, then the result waits in MUL_DONE for ready_i
// start_i must stay high until the result is taken; a drop aborts
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module ex_mult #(
  parameter int unsigned XLEN = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  input  ex_op_pkg::mul_op_e operator_i,
  input  logic [XLEN-1:0]    op_a_i,
  input  logic [XLEN-1:0]    op_b_i,
  input  logic               ready_i,
  output logic [XLEN-1:0]    result_o,
  output logic               valid_o,
  output logic               ready_o
);

  localparam int unsigned CNT_W = $clog2(XLEN + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(XLEN - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(XLEN);

  // Control
  ex_op_pkg::mul_state_e state_q;
  ex_op_pkg::mul_state_e state_d;
  logic [CNT_W-1:0]      cnt_q;
  logic                  load_en;
  logic                  calc_en;

  // Datapath
  ex_op_pkg::mul_op_e op_q;
  logic [XLEN-1:0]    mcand_q;
  logic [2*XLEN-1:0]  acc_q;
  logic [XLEN:0]      addend;
  logic [XLEN:0]      psum;

  assign load_en = (state_q == ex_op_pkg::MUL_IDLE) && start_i;
  assign calc_en = (state_q == ex_op_pkg::MUL_CALC);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_op_pkg::MUL_IDLE: if (start_i) state_d = ex_op_pkg::MUL_CALC;
      ex_op_pkg::MUL_CALC: begin
        if (!start_i) state_d = ex_op_pkg::MUL_IDLE;
        else if (cnt_q == CNT_LAST) state_d = ex_op_pkg::MUL_DONE;
      end
      // Leave once taken, or when the instruction is gone
      ex_op_pkg::MUL_DONE: if (!start_i || ready_i) state_d = ex_op_pkg::MUL_IDLE;
      default:             state_d = ex_op_pkg::MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_op_pkg::MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (load_en) cnt_q <= '0;
      else if (calc_en) cnt_q <= cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulator
  //////////////////////////////////////////////////////////////////////

  // Multiplier sits in the low half and shifts out one bit per cycle
  assign addend = acc_q[0] ? {1'b0, mcand_q} : '0;
  assign psum   = {1'b0, acc_q[2*XLEN-1:XLEN]} + addend;

  always_ff @(posedge clk) begin
    if (load_en) begin
      op_q    <= operator_i;
      mcand_q <= op_a_i;
      acc_q   <= {{XLEN{1'b0}}, op_b_i};
    end else if (calc_en) begin
      acc_q <= {psum, acc_q[XLEN-1:1]};
    end
  end

  assign result_o = (op_q == ex_op_pkg::MUL_HU) ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];
  assign valid_o  = (state_q == ex_op_pkg::MUL_DONE);
  assign ready_o  = valid_o && ready_i;

  // A result is only offered after the full XLEN iterations
  a_valid_done: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> (state_q == ex_op_pkg::MUL_DONE) && (cnt_q == CNT_FULL))
    else $error("multiplier result offered before all iterations");

  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= CNT_FULL)
    else $error("multiplier iteration counter out of range");

endmodule : ex_mult

`default_nettype wire

// File: logic/ex_op_pkg.sv
//////////////////////////////////////////////////////////////////////
// Opcode, unit-select and FSM state encodings of the execute stage
// Encodings are fixed by decode; reorder only together with it
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ex_op_pkg;

  // ALU opcodes, all 16 codes in use
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch comparisons
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Multiplier opcodes, low product or unsigned high product
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HU = 1'b1
  } mul_op_e;

  // Functional unit that produces the result
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } ex_unit_e;

  // Multiplier FSM
  typedef enum logic [1:0] {
    MUL_IDLE = 2'b00,
    MUL_CALC = 2'b01,
    MUL_DONE = 2'b10
  } mul_state_e;

endpackage : ex_op_pkg

`default_nettype wire

// File: logic/ex_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute stage top level with ALU and iterative multiplier
// Decode holds the instruction fields stable until ex_ready_o
// kill_i drops the instruction in EX without a result
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module ex_stage #(
  parameter int unsigned XLEN      = ex_cfg_pkg::XLEN,
  parameter int unsigned REGADDR_W = ex_cfg_pkg::REGADDR_W
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Decode side
  input  logic                 instr_valid_i,
  input  logic                 kill_i,
  input  ex_op_pkg::ex_unit_e  unit_i,
  input  ex_op_pkg::alu_op_e   alu_op_i,
  input  ex_op_pkg::mul_op_e   mul_op_i,
  input  logic [XLEN-1:0]      operand_a_i,
  input  logic [XLEN-1:0]      operand_b_i,
  input  logic                 branch_i,
  input  logic                 rf_we_i,
  input  logic [REGADDR_W-1:0] rf_waddr_i,
  // Writeback side
  input  logic                 wb_ready_i,
  output logic                 ex_ready_o,
  output logic                 branch_decision_o,
  output logic                 wb_valid_o,
  output logic                 wb_rf_we_o,
  output logic [REGADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]      wb_rf_wdata_o,
  output logic                 wb_bch_taken_o
);

  // Stage control
  logic instr_valid;
  logic is_mul;
  logic mul_start;
  logic ex_valid;
  logic wb_load;

  // Unit results and handshake
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic [XLEN-1:0] mul_result;
  logic            mul_valid;
  logic            mul_ready;
  logic [XLEN-1:0] ex_result;
  logic            bch_taken;

  // Only place where kill masks the instruction
  assign instr_valid = instr_valid_i && !kill_i;
  assign is_mul      = (unit_i == ex_op_pkg::UNIT_MUL);
  assign mul_start   = instr_valid && is_mul;

  //////////////////////////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////////////////////////

  ex_alu #(
    .XLEN (XLEN)
  ) u_alu (
    .operator_i   (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  ex_mult #(
    .XLEN (XLEN)
  ) u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (mul_start),
    .operator_i (mul_op_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .ready_i    (wb_ready_i),
    .result_o   (mul_result),
    .valid_o    (mul_valid),
    .ready_o    (mul_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Result select and stage handshake
  //////////////////////////////////////////////////////////////////////

  assign ex_result         = is_mul ? mul_result : alu_result;
  assign branch_decision_o = alu_cmp;
  // Branch flag only counts for ALU instructions
  assign bch_taken         = branch_i && !is_mul && alu_cmp;

  // ALU result is valid at once, the multiplier reports its own
  assign ex_valid   = instr_valid && (!is_mul || mul_valid);
  assign wb_load    = ex_valid && wb_ready_i;
  assign ex_ready_o = kill_i || (wb_ready_i && (!mul_start || mul_ready));

  ex_wb_reg #(
    .XLEN      (XLEN),
    .REGADDR_W (REGADDR_W)
  ) u_wb_reg (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_i         (wb_load),
    .wb_ready_i     (wb_ready_i),
    .rf_we_i        (rf_we_i),
    .rf_waddr_i     (rf_waddr_i),
    .rf_wdata_i     (ex_result),
    .bch_taken_i    (bch_taken),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_bch_taken_o (wb_bch_taken_o)
  );

  // Kill never starts a multiply and leaves no result behind next cycle
  a_kill_mul: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> !mul_start ##1 !mul_valid)
    else $error("multiply started or finished across a kill");

endmodule : ex_stage

`default_nettype wire

// File: logic/ex_wb_reg.sv
//////////////////////////////////////////////////////////////////////
// EX/WB pipeline register with bubble insertion
// Address and data update only for writing instructions
// Holds everything while WB stalls
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module ex_wb_reg #(
  parameter int unsigned XLEN      = 32,
  parameter int unsigned REGADDR_W = ex_cfg_pkg::REGADDR_W
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_i,
  input  logic                 wb_ready_i,
  input  logic                 rf_we_i,
  input  logic [REGADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]      rf_wdata_i,
  input  logic                 bch_taken_i,
  output logic                 wb_valid_o,
  output logic                 wb_rf_we_o,
  output logic [REGADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]      wb_rf_wdata_o,
  output logic                 wb_bch_taken_o
);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_bch_taken_o <= 1'b0;
    end else if (load_i) begin
      wb_valid_o     <= 1'b1;
      wb_rf_we_o     <= rf_we_i;
      wb_bch_taken_o <= bch_taken_i;
    end else if (wb_ready_i) begin
      // WB drained and nothing finished in EX
      wb_valid_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  // Non-writing instructions leave the last address and data in place
  always_ff @(posedge clk) begin
    if (load_i && rf_we_i) begin
      wb_rf_waddr_o <= rf_waddr_i;
      wb_rf_wdata_o <= rf_wdata_i;
    end
  end

  // EX may only hand over when WB accepts
  a_load_ready: assert property (@(posedge clk) disable iff (!rst_n) load_i |-> wb_ready_i)
    else $error("EX/WB register loaded while WB stalls");

endmodule : ex_wb_reg

`default_nettype wire

// File: include/tb_ex_vectors.svh
//////////////////////////////////////////////////////////////////////
// Stimulus table for the execute stage testbench
// Operand constants are written for XLEN of 32 and truncate at 16
// Stall counts must stay at or below MAX_STALL of the testbench
// Kill rows stall for the listed cycles, then kill the instruction
//////////////////////////////////////////////////////////////////////

`ifndef TB_EX_VECTORS_SVH
`define TB_EX_VECTORS_SVH

// Columns: opcode, operand A, operand B, rf_we, rd, [branch,] kill, stalls, random
task automatic fill_vector_table();
  // Arithmetic, logic and shifts
  add_alu(ex_op_pkg::ALU_ADD,  32'h0000_0005, 32'h0000_0007, 1, 5'd1,  0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_ADD,  32'hFFFF_FFFF, 32'h0000_0001, 1, 5'd2,  0, 0, 2, 0);
  add_alu(ex_op_pkg::ALU_SUB,  32'h0000_0003, 32'h0000_0005, 1, 5'd3,  0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_AND,  32'hF0F0_FF00, 32'h0FF0_0FF0, 1, 5'd4,  0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_OR,   32'hF0F0_FF00, 32'h0FF0_0FF0, 1, 5'd5,  0, 0, 1, 0);
  add_alu(ex_op_pkg::ALU_XOR,  32'hF0F0_FF00, 32'h0FF0_0FF0, 1, 5'd6,  0, 0, 0, 0);
  // Only the low bits of B count as shift amount
  add_alu(ex_op_pkg::ALU_SLL,  32'h0000_0001, 32'h0000_003F, 1, 5'd7,  0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_SLL,  32'hA5A5_A5A5, 32'h0000_0024, 1, 5'd8,  0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_SRL,  32'h8000_0000, 32'h0000_0004, 1, 5'd9,  0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_SRA,  32'h8000_0000, 32'h0000_0004, 1, 5'd10, 0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_SRA,  32'h7FFF_FFF0, 32'hFFFF_FFE4, 1, 5'd11, 0, 0, 0, 0);
  // Set-less-than
  add_alu(ex_op_pkg::ALU_SLT,  32'hFFFF_FFFF, 32'h0000_0001, 1, 5'd12, 0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 1, 5'd13, 0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_SLT,  32'h0000_0001, 32'hFFFF_FFFF, 1, 5'd14, 0, 0, 3, 0);
  // Branches, no register write
  add_alu(ex_op_pkg::ALU_EQ,   32'h0000_1234, 32'h0000_1234, 0, 5'd0,  1, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_NE,   32'h0000_1234, 32'h0000_1234, 0, 5'd0,  1, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_LT,   32'h8000_0000, 32'h0000_0000, 0, 5'd0,  1, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_GE,   32'h8000_0000, 32'h0000_0000, 0, 5'd0,  1, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_LTU,  32'h8000_0000, 32'h0000_0000, 0, 5'd0,  1, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_GEU,  32'h8000_0000, 32'h0000_0000, 0, 5'd0,  1, 0, 4, 0);
  // Comparison true but not a branch
  add_alu(ex_op_pkg::ALU_LT,   32'h0000_0000, 32'h0000_0001, 0, 5'd0,  0, 0, 0, 0);
  add_alu(ex_op_pkg::ALU_ADD,  32'h0000_0011, 32'h0000_0022, 0, 5'd15, 0, 0, 0, 0);
  // Multiplies, corners first
  add_mul(ex_op_pkg::MUL_LO,   32'h0000_0000, 32'hFFFF_FFFF, 1, 5'd16, 0, 0, 0);
  add_mul(ex_op_pkg::MUL_HU,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 1, 5'd17, 0, 0, 0);
  add_mul(ex_op_pkg::MUL_LO,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 1, 5'd18, 0, 3, 0);
  add_mul(ex_op_pkg::MUL_HU,   32'h8000_0000, 32'h8000_0000, 1, 5'd19, 0, 0, 0);
  add_mul(ex_op_pkg::MUL_LO,   32'h8000_0000, 32'h0000_0003, 1, 5'd20, 0, 0, 0);
  add_mul(ex_op_pkg::MUL_HU,   32'h0000_0000, 32'h0000_0000, 1, 5'd21, 0, 0, 1);
  add_mul(ex_op_pkg::MUL_LO,   32'h0000_0000, 32'h0000_0000, 1, 5'd22, 0, 0, 1);
  // Kill of an ALU op, then of a multiply mid-way and at start
  add_alu(ex_op_pkg::ALU_ADD,  32'h0000_0001, 32'h0000_0001, 1, 5'd23, 0, 1, 0, 0);
  add_alu(ex_op_pkg::ALU_ADD,  32'h0000_0010, 32'h0000_0020, 1, 5'd24, 0, 0, 0, 0);
  add_mul(ex_op_pkg::MUL_LO,   32'h0000_0007, 32'h0000_0009, 1, 5'd25, 1, 10, 0);
  add_mul(ex_op_pkg::MUL_HU,   32'h1234_5678, 32'h9ABC_DEF0, 1, 5'd26, 0, 0, 0);
  add_mul(ex_op_pkg::MUL_LO,   32'h0000_0003, 32'h0000_0003, 1, 5'd27, 1, 0, 0);
  // Random operands and stalls
  add_alu(ex_op_pkg::ALU_ADD,  32'h0000_0000, 32'h0000_0000, 1, 5'd28, 0, 0, 0, 1);
  add_alu(ex_op_pkg::ALU_SUB,  32'h0000_0000, 32'h0000_0000, 1, 5'd29, 0, 0, 0, 1);
  add_alu(ex_op_pkg::ALU_SRA,  32'h0000_0000, 32'h0000_0000, 1, 5'd30, 0, 0, 0, 1);
  add_alu(ex_op_pkg::ALU_SLTU, 32'h0000_0000, 32'h0000_0000, 1, 5'd31, 0, 0, 0, 1);
  add_alu(ex_op_pkg::ALU_GE,   32'h0000_0000, 32'h0000_0000, 0, 5'd0,  1, 0, 0, 1);
  add_alu(ex_op_pkg::ALU_XOR,  32'h0000_0000, 32'h0000_0000, 1, 5'd1,  0, 0, 0, 1);
endtask

`endif

// File: testbench/tb_ex_stage.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the execute stage at the package default widths
// Inputs change on the falling edge and outputs are read on the rising edge
// The first mismatch ends the run
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module tb_ex_stage;

  localparam int unsigned XLEN         = ex_cfg_pkg::XLEN;
  localparam int unsigned REGADDR_W    = ex_cfg_pkg::REGADDR_W;
  localparam int unsigned SHAMT_W      = $clog2(XLEN);
  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 5;
  localparam int          MAX_STALL    = 12;

  // DUT ports
  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid_i;
  logic                  kill_i;
  ex_op_pkg::ex_unit_e   unit_i;
  ex_op_pkg::alu_op_e    alu_op_i;
  ex_op_pkg::mul_op_e    mul_op_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       operand_b_i;
  logic                  branch_i;
  logic                  rf_we_i;
  logic [REGADDR_W-1:0]  rf_waddr_i;
  logic                  wb_ready_i;
  logic                  ex_ready_o;
  logic                  branch_decision_o;
  logic                  wb_valid_o;
  logic                  wb_rf_we_o;
  logic [REGADDR_W-1:0]  wb_rf_waddr_o;
  logic [XLEN-1:0]       wb_rf_wdata_o;
  logic                  wb_bch_taken_o;

  // Vector table with one queue per column
  ex_op_pkg::ex_unit_e   vec_unit[$];
  ex_op_pkg::alu_op_e    vec_alu_op[$];
  ex_op_pkg::mul_op_e    vec_mul_op[$];
  logic [XLEN-1:0]       vec_a[$];
  logic [XLEN-1:0]       vec_b[$];
  logic                  vec_we[$];
  logic [REGADDR_W-1:0]  vec_rd[$];
  logic                  vec_br[$];
  logic                  vec_kill[$];
  int                    vec_stall[$];
  logic                  vec_rnd[$];

  // Writes still owed by WB in issue order
  int                    exp_idx_q[$];
  logic                  exp_we_q[$];
  logic [REGADDR_W-1:0]  exp_rd_q[$];
  logic [XLEN-1:0]       exp_data_q[$];
  logic                  exp_bch_q[$];

  logic [31:0]           lcg_state;
  logic                  table_loaded;

  ex_stage #(
    .XLEN      (XLEN),
    .REGADDR_W (REGADDR_W)
  ) u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid_i     (instr_valid_i),
    .kill_i            (kill_i),
    .unit_i            (unit_i),
    .alu_op_i          (alu_op_i),
    .mul_op_i          (mul_op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .branch_i          (branch_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .wb_ready_i        (wb_ready_i),
    .ex_ready_o        (ex_ready_o),
    .branch_decision_o (branch_decision_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_bch_taken_o    (wb_bch_taken_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Table helpers and random source
  //////////////////////////////////////////////////////////////////////

  task automatic add_alu(input ex_op_pkg::alu_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic we,
                         input logic [REGADDR_W-1:0] rd, input logic br, input logic kill,
                         input int stall, input logic rnd);
    vec_unit.push_back(ex_op_pkg::UNIT_ALU);
    vec_alu_op.push_back(op);
    vec_mul_op.push_back(ex_op_pkg::MUL_LO);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_we.push_back(we);
    vec_rd.push_back(rd);
    vec_br.push_back(br);
    vec_kill.push_back(kill);
    vec_stall.push_back(stall);
    vec_rnd.push_back(rnd);
  endtask

  task automatic add_mul(input ex_op_pkg::mul_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic we,
                         input logic [REGADDR_W-1:0] rd, input logic kill,
                         input int stall, input logic rnd);
    vec_unit.push_back(ex_op_pkg::UNIT_MUL);
    vec_alu_op.push_back(ex_op_pkg::ALU_ADD);
    vec_mul_op.push_back(op);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_we.push_back(we);
    vec_rd.push_back(rd);
    vec_br.push_back(1'b0);
    vec_kill.push_back(kill);
    vec_stall.push_back(stall);
    vec_rnd.push_back(rnd);
  endtask

  `include "tb_ex_vectors.svh"

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Enough LCG words to fill one operand
  function automatic logic [XLEN-1:0] random_word();
    logic [XLEN+31:0] w;
    w = '0;
    for (int k = 0; k < XLEN; k += 32) begin
      w = {w[XLEN-1:0], lcg_next()};
    end
    return w[XLEN-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic ref_compare(input ex_op_pkg::alu_op_e op,
                                       input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [XLEN-1:0] msb;
    logic            slt;
    logic            sltu;
    // Flipping the sign bit maps signed order onto unsigned order
    msb  = {1'b1, {(XLEN-1){1'b0}}};
    sltu = (a < b);
    slt  = ((a ^ msb) < (b ^ msb));
    case (op)
      ex_op_pkg::ALU_SLT, ex_op_pkg::ALU_LT:   return slt;
      ex_op_pkg::ALU_SLTU, ex_op_pkg::ALU_LTU: return sltu;
      ex_op_pkg::ALU_EQ:                       return (a == b);
      ex_op_pkg::ALU_NE:                       return (a != b);
      ex_op_pkg::ALU_GE:                       return !slt;
      ex_op_pkg::ALU_GEU:                      return !sltu;
      default:                                 return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] ref_alu(input ex_op_pkg::alu_op_e op,
                                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    int unsigned     sh;
    logic [XLEN-1:0] sign_fill;
    sh = b[SHAMT_W-1:0];
    // Copies of the sign bit that enter from the top
    sign_fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
    case (op)
      ex_op_pkg::ALU_ADD: return a + b;
      ex_op_pkg::ALU_SUB: return a + ~b + 1'b1;
      ex_op_pkg::ALU_AND: return a & b;
      ex_op_pkg::ALU_OR:  return a | b;
      ex_op_pkg::ALU_XOR: return a ^ b;
      ex_op_pkg::ALU_SLL: return a << sh;
      ex_op_pkg::ALU_SRL: return a >> sh;
      ex_op_pkg::ALU_SRA: return (a >> sh) | sign_fill;
      default:            return {{(XLEN-1){1'b0}}, ref_compare(op, a, b)};
    endcase
  endfunction

  function automatic logic [XLEN-1:0] ref_mul(input ex_op_pkg::mul_op_e op,
                                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] prod;
    prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    return (op == ex_op_pkg::MUL_HU) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch on %s", what);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "%s", reason);
  endtask

  // A beat is a cycle with wb_valid_o and wb_ready_i both high
  always @(posedge clk) begin
    if (rst_n && wb_valid_o && wb_ready_i) begin
      if (exp_idx_q.size() == 0) begin
        abort_run("A write-back beat appeared with no accepted instruction pending");
      end else begin
        check_value($sformatf("entry %0d wb_rf_we_o", exp_idx_q[0]), wb_rf_we_o, exp_we_q[0]);
        check_value($sformatf("entry %0d wb_bch_taken_o", exp_idx_q[0]), wb_bch_taken_o,
                    exp_bch_q[0]);
        // Address and data only move for writing instructions
        if (exp_we_q[0]) begin
          check_value($sformatf("entry %0d wb_rf_waddr_o", exp_idx_q[0]), wb_rf_waddr_o,
                      exp_rd_q[0]);
          check_value($sformatf("entry %0d wb_rf_wdata_o", exp_idx_q[0]), wb_rf_wdata_o,
                      exp_data_q[0]);
        end
        void'(exp_idx_q.pop_front());
        void'(exp_we_q.pop_front());
        void'(exp_rd_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_bch_q.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic issue_entry(input int idx);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] exp_data;
    logic            exp_cmp;
    logic            is_alu;
    int              stall;
    int              busy;
    a      = vec_a[idx];
    b      = vec_b[idx];
    stall  = vec_stall[idx];
    is_alu = (vec_unit[idx] == ex_op_pkg::UNIT_ALU);
    if (vec_rnd[idx]) begin
      a     = random_word();
      b     = random_word();
      stall = lcg_next() % 4;
    end
    if (is_alu) begin
      exp_data = ref_alu(vec_alu_op[idx], a, b);
      exp_cmp  = ref_compare(vec_alu_op[idx], a, b);
    end else begin
      exp_data = ref_mul(vec_mul_op[idx], a, b);
      exp_cmp  = 1'b0;
    end
    busy = 0;
    @(negedge clk);
    instr_valid_i = 1'b1;
    kill_i        = 1'b0;
    unit_i        = vec_unit[idx];
    alu_op_i      = vec_alu_op[idx];
    mul_op_i      = vec_mul_op[idx];
    operand_a_i   = a;
    operand_b_i   = b;
    branch_i      = vec_br[idx];
    rf_we_i       = vec_we[idx];
    rf_waddr_i    = vec_rd[idx];
    // WB back-pressure first so nothing may leave EX meanwhile
    if (stall > 0) begin
      wb_ready_i = 1'b0;
      repeat (stall) begin
        @(posedge clk);
        check_value($sformatf("entry %0d ex_ready_o in stall", idx), ex_ready_o, 0);
        busy++;
      end
      @(negedge clk);
    end
    wb_ready_i = 1'b1;
    kill_i     = vec_kill[idx];
    @(posedge clk);
    if (vec_kill[idx]) begin
      check_value($sformatf("entry %0d ex_ready_o on kill", idx), ex_ready_o, 1);
    end else begin
      if (is_alu) begin
        check_value($sformatf("entry %0d branch_decision_o", idx), branch_decision_o, exp_cmp);
        check_value($sformatf("entry %0d ex_ready_o", idx), ex_ready_o, 1);
      end else begin
        while (!ex_ready_o) begin
          busy++;
          if (busy > XLEN + MAX_STALL + 4) begin
            abort_run($sformatf("Multiply of entry %0d never handed over its result", idx));
          end else begin
            @(posedge clk);
          end
        end
        // Result cannot be taken before all iterations ran
        check_value($sformatf("entry %0d multiply busy span", idx), busy >= XLEN, 1);
      end
      exp_idx_q.push_back(idx);
      exp_we_q.push_back(vec_we[idx]);
      exp_rd_q.push_back(vec_rd[idx]);
      exp_data_q.push_back(exp_data);
      exp_bch_q.push_back(vec_br[idx] && is_alu && exp_cmp);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    kill_i        = 1'b0;
    unit_i        = ex_op_pkg::UNIT_ALU;
    alu_op_i      = ex_op_pkg::ALU_ADD;
    mul_op_i      = ex_op_pkg::MUL_LO;
    operand_a_i   = '0;
    operand_b_i   = '0;
    branch_i      = 1'b0;
    rf_we_i       = 1'b0;
    rf_waddr_i    = '0;
    wb_ready_i    = 1'b0;
    lcg_state     = 32'h679e;
    fill_vector_table();
    table_loaded  = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    check_value("wb_valid_o in reset", wb_valid_o, 0);
    check_value("wb_rf_we_o in reset", wb_rf_we_o, 0);
    check_value("wb_bch_taken_o in reset", wb_bch_taken_o, 0);
    @(negedge clk);
    rst_n      = 1'b1;
    wb_ready_i = 1'b1;
    // Idle stage after reset
    repeat (3) begin
      @(posedge clk);
      check_value("wb_valid_o before first instruction", wb_valid_o, 0);
    end
    for (int i = 0; i < vec_unit.size(); i++) begin
      issue_entry(i);
    end
    @(negedge clk);
    instr_valid_i = 1'b0;
    kill_i        = 1'b0;
    // Drain WB and then look for stray beats
    while (exp_idx_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    check_value("wb_valid_o after drain", wb_valid_o, 0);
    $display("Regression passed");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_loaded === 1'b1);
    #((vec_unit.size() * (XLEN + MAX_STALL + 8) + RESET_CYCLES + 20) * CLK_PERIOD);
    abort_run("Watchdog expired before the vector table completed");
  end

endmodule : tb_ex_stage

`default_nettype wire
